// File: src/u1e_pkg.sv
package u1e_pkg;

   //////////////////////////////////////////////////////////////////////
   // host bus and settings bus types

   typedef logic [15:0] wb_data_t;    // host data word
   typedef logic [10:0] wb_addr_t;    // host word address
   typedef logic [1:0]  wb_sel_t;     // byte lanes

   typedef logic [7:0]  set_addr_t;   // settings register number
   typedef logic [31:0] set_data_t;   // settings value

   typedef logic [63:0] vita_time_t;  // ticks of wb_clk

   //////////////////////////////////////////////////////////////////////
   // address decode, top DECODE_W bits of the word address

   localparam int DECODE_W = 4;

   localparam logic [DECODE_W-1:0] SLV_MISC          = 4'h0;
   localparam logic [DECODE_W-1:0] SLV_READBACK      = 4'h7;
   localparam logic [DECODE_W-1:0] SLV_SETTINGS      = 4'h8;
   localparam logic [DECODE_W-1:0] SLV_SETTINGS_MASK = 4'hE;  // 8 and 9

   localparam wb_data_t UNMAPPED_DATA = 16'h0000;

   //////////////////////////////////////////////////////////////////////
   // settings bus register numbers

   localparam set_addr_t SR_TIME64       = 8'd40;  // +0 high, +1 low
   localparam set_addr_t SR_GLOBAL_RESET = 8'd50;
   localparam set_addr_t SR_REG_TEST32   = 8'd52;

   //////////////////////////////////////////////////////////////////////
   // misc block offsets, low 7 address bits

   localparam logic [6:0] REG_LEDS      = 7'd0;
   localparam logic [6:0] REG_CGEN_CTRL = 7'd4;
   localparam logic [6:0] REG_CGEN_ST   = 7'd6;
   localparam logic [6:0] REG_TEST      = 7'd8;
   localparam logic [6:0] REG_COMPAT    = 7'd16;

   // misc constants
   localparam logic [7:0] COMPAT_NUM        = 8'd4;
   localparam wb_data_t   MISC_DEFAULT_DATA = 16'hBEEF;
   localparam logic [1:0] CGEN_CTRL_RESET   = 2'b11;  // sync_b and ref_sel high

endpackage

// File: src/u1e_reset_ctrl.sv
module u1e_reset_ctrl
  #(parameter int RESET_HOLD = 8)
  (
   input  logic                wb_clk,
   input  logic                wb_rst,
   input  logic                set_stb_i,
   input  u1e_pkg::set_addr_t  set_addr_i,
   output logic                core_rst_o
  );

   localparam int CNT_W = $clog2(RESET_HOLD + 1);

   logic [CNT_W-1:0] hold_cnt;
   logic             global_reset;

   assign global_reset = set_stb_i & (set_addr_i == u1e_pkg::SR_GLOBAL_RESET);

   // reload on either source, then count down to zero
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst | global_reset)
         hold_cnt <= CNT_W'(RESET_HOLD);
      else if (hold_cnt != '0)
         hold_cnt <= hold_cnt - 1'b1;
   end

   assign core_rst_o = wb_rst | (hold_cnt != '0);

endmodule

// File: src/u1e_bus_decoder.sv
module u1e_bus_decoder
  (
   input  logic               wb_clk,
   input  logic               rst_i,
   input  u1e_pkg::wb_addr_t  wb_adr_i,
   input  u1e_pkg::wb_sel_t   wb_sel_i,
   input  logic               wb_we_i,
   input  logic               wb_cyc_i,
   input  logic               wb_stb_i,
   output u1e_pkg::wb_data_t  wb_dat_o,
   output logic               wb_ack_o,
   output logic               misc_stb_o,
   input  logic               misc_ack_i,
   input  u1e_pkg::wb_data_t  misc_dat_i,
   output logic               rb_stb_o,
   input  logic               rb_ack_i,
   input  u1e_pkg::wb_data_t  rb_dat_i,
   output logic               set_stb_o,
   input  logic               set_ack_i,
   input  u1e_pkg::wb_data_t  set_dat_i
  );

   localparam int AW = $bits(u1e_pkg::wb_addr_t);

   logic [u1e_pkg::DECODE_W-1:0] slot;
   logic hit_misc, hit_rb, hit_set;
   logic bus_en;     // low through reset and one cycle after
   logic req, null_wr, pass;

   assign slot     = wb_adr_i[AW-1 -: u1e_pkg::DECODE_W];
   assign hit_misc = (slot == u1e_pkg::SLV_MISC);
   assign hit_rb   = (slot == u1e_pkg::SLV_READBACK);
   assign hit_set  = ((slot & u1e_pkg::SLV_SETTINGS_MASK) ==
                      (u1e_pkg::SLV_SETTINGS & u1e_pkg::SLV_SETTINGS_MASK));

   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
         bus_en <= 1'b0;
      else
         bus_en <= 1'b1;
   end

   assign req     = wb_cyc_i & wb_stb_i & bus_en & ~rst_i;
   assign null_wr = wb_we_i & ~|wb_sel_i;   // write with no lanes, ack only
   assign pass    = req & ~null_wr;

   assign misc_stb_o = pass & hit_misc;
   assign rb_stb_o   = pass & hit_rb;
   assign set_stb_o  = pass & hit_set;

   ////////////////////////////////////////////////////////////////////
   // return path
   always_comb
   begin
      wb_ack_o = req;                       // unmapped answers at once
      wb_dat_o = u1e_pkg::UNMAPPED_DATA;
      if (!null_wr)
      begin
         if (hit_misc)
         begin
            wb_ack_o = misc_ack_i;
            wb_dat_o = misc_dat_i;
         end
         else if (hit_rb)
         begin
            wb_ack_o = rb_ack_i;            // one cycle late
            wb_dat_o = rb_dat_i;
         end
         else if (hit_set)
         begin
            wb_ack_o = set_ack_i;
            wb_dat_o = set_dat_i;
         end
      end
   end

endmodule

// File: src/u1e_misc_regs.sv
module u1e_misc_regs
  (
   input  logic               wb_clk,
   input  logic               rst_i,
   input  u1e_pkg::wb_addr_t  adr_i,
   input  u1e_pkg::wb_data_t  dat_i,
   input  logic               we_i,
   input  logic               stb_i,
   output u1e_pkg::wb_data_t  dat_o,
   output logic               ack_o,
   input  logic               cgen_st_status_i,
   input  logic               cgen_st_ld_i,
   input  logic               cgen_st_refmon_i,
   output logic [3:0]         led_o,
   output logic               cgen_sync_b_o,
   output logic               cgen_ref_sel_o
  );

   u1e_pkg::wb_data_t reg_leds;
   u1e_pkg::wb_data_t reg_test;
   logic [1:0]        reg_cgen_ctrl;   // {sync_b, ref_sel}
   logic [6:0]        offset;

   assign offset = adr_i[6:0];
   assign ack_o  = stb_i;    // zero wait state

   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= u1e_pkg::CGEN_CTRL_RESET;
         reg_test      <= '0;
      end
      else if (stb_i & we_i)
      begin
         case (offset)
            u1e_pkg::REG_LEDS      : reg_leds      <= dat_i;
            u1e_pkg::REG_CGEN_CTRL : reg_cgen_ctrl <= dat_i[1:0];
            u1e_pkg::REG_TEST      : reg_test      <= dat_i;
            default                : ;   // read-only or unknown
         endcase
      end
   end

   // read mux
   always_comb
   begin
      case (offset)
         u1e_pkg::REG_LEDS      : dat_o = reg_leds;
         u1e_pkg::REG_CGEN_CTRL : dat_o = {14'd0, reg_cgen_ctrl};
         u1e_pkg::REG_CGEN_ST   :
            dat_o = {13'd0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         u1e_pkg::REG_TEST      : dat_o = reg_test;
         u1e_pkg::REG_COMPAT    : dat_o = {8'd0, u1e_pkg::COMPAT_NUM};
         default                : dat_o = u1e_pkg::MISC_DEFAULT_DATA;
      endcase
   end

   // LEDs are active low
   assign led_o = ~reg_leds[3:0];

   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];

endmodule

// File: src/u1e_settings_bridge.sv
module u1e_settings_bridge
  (
   input  logic                wb_clk,
   input  logic                rst_i,
   input  u1e_pkg::wb_addr_t   adr_i,
   input  u1e_pkg::wb_data_t   dat_i,
   input  logic                we_i,
   input  logic                stb_i,
   output logic                ack_o,
   output logic                set_stb_o,
   output u1e_pkg::set_addr_t  set_addr_o,
   output u1e_pkg::set_data_t  set_data_o
  );

   u1e_pkg::wb_data_t low_half;   // held until the odd word arrives
   logic              wr_even;
   logic              wr_odd;

   // reads land here too and just get an ack, data comes back as 0
   assign ack_o = stb_i;

   assign wr_even = stb_i & we_i & ~adr_i[0];
   assign wr_odd  = stb_i & we_i &  adr_i[0];

   always_ff @(posedge wb_clk)
   begin
      if (wr_even)
         low_half <= dat_i;
   end

   ////////////////////////////////////////////////////////////////////
   // odd word completes the setting
   always_ff @(posedge wb_clk)
   begin
      if (wr_odd)
      begin
         set_addr_o <= {2'b00, adr_i[6:1]};   // 64 registers
         set_data_o <= {dat_i, low_half};
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
         set_stb_o <= 1'b0;
      else
         set_stb_o <= wr_odd;   // one cycle after the ack
   end

endmodule

// File: src/u1e_time_keeper.sv
module u1e_time_keeper
  (
   input  logic                 wb_clk,
   input  logic                 rst_i,
   input  logic                 set_stb_i,
   input  u1e_pkg::set_addr_t   set_addr_i,
   input  u1e_pkg::set_data_t   set_data_i,
   input  logic                 pps_i,
   output u1e_pkg::vita_time_t  vita_time_o,
   output u1e_pkg::vita_time_t  vita_time_pps_o
  );

   u1e_pkg::set_data_t pending_hi;
   logic               set_hi;
   logic               set_lo;
   logic               tick;       // counter advances on every other cycle
   logic [1:0]         pps_sync;
   logic               pps_dly;    // edge register
   logic               pps_edge;

   assign set_hi = set_stb_i & (set_addr_i == u1e_pkg::SR_TIME64);
   assign set_lo = set_stb_i & (set_addr_i == u1e_pkg::set_addr_t'(u1e_pkg::SR_TIME64 + 1));

   always_ff @(posedge wb_clk)
   begin
      if (set_hi)
         pending_hi <= set_data_i;
   end

   ////////////////////////////////////////////////////////////////////
   // time counter
   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
      begin
         vita_time_o <= '0;
         tick        <= 1'b0;
      end
      else
      begin
         tick <= ~tick;
         if (set_lo)
            vita_time_o <= {pending_hi, set_data_i};   // seen next cycle
         else if (tick)
            vita_time_o <= vita_time_o + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // pps capture
   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
      begin
         pps_sync <= 2'b00;
         pps_dly  <= 1'b0;
      end
      else
      begin
         pps_sync <= {pps_sync[0], pps_i};
         pps_dly  <= pps_sync[1];
      end
   end

   assign pps_edge = pps_sync[1] & ~pps_dly;

   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
         vita_time_pps_o <= '0;
      else if (pps_edge)
         vita_time_pps_o <= vita_time_o;
   end

endmodule

// File: src/u1e_readback_regs.sv
module u1e_readback_regs
  (
   input  logic                 wb_clk,
   input  logic                 rst_i,
   input  u1e_pkg::wb_addr_t    adr_i,
   input  logic                 stb_i,
   input  logic                 cyc_i,
   output u1e_pkg::wb_data_t    dat_o,
   output logic                 ack_o,
   input  logic                 set_stb_i,
   input  u1e_pkg::set_addr_t   set_addr_i,
   input  u1e_pkg::set_data_t   set_data_i,
   input  u1e_pkg::vita_time_t  vita_time_i,
   input  u1e_pkg::vita_time_t  vita_time_pps_i
  );

   u1e_pkg::set_data_t reg_test32;
   u1e_pkg::set_data_t rd_word;
   logic               acked;    // stb still high after our ack

   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
         reg_test32 <= '0;
      else if (set_stb_i & (set_addr_i == u1e_pkg::SR_REG_TEST32))
         reg_test32 <= set_data_i;
   end

   ////////////////////////////////////////////////////////////////////
   // 32-bit word select, bit 0 picks the half
   always_comb
   begin
      case (adr_i[4:1])
         4'd0    : rd_word = vita_time_i[63:32];
         4'd1    : rd_word = vita_time_i[31:0];
         4'd2    : rd_word = vita_time_pps_i[63:32];
         4'd3    : rd_word = vita_time_pps_i[31:0];
         4'd4    : rd_word = reg_test32;
         default : rd_word = '0;
      endcase
   end

   always_ff @(posedge wb_clk)
   begin
      dat_o <= adr_i[0] ? rd_word[31:16] : rd_word[15:0];   // low half at even
   end

   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
      begin
         ack_o <= 1'b0;
         acked <= 1'b0;
      end
      else
      begin
         ack_o <= stb_i & cyc_i & ~ack_o & ~acked;
         acked <= stb_i & (acked | ack_o);
      end
   end

endmodule

// File: src/u1e_core.sv
module u1e_core
  #(parameter int RESET_HOLD = 8)
  (
   input  logic               wb_clk,
   input  logic               wb_rst,
   input  u1e_pkg::wb_addr_t  wb_adr_i,
   input  u1e_pkg::wb_data_t  wb_dat_i,
   input  u1e_pkg::wb_sel_t   wb_sel_i,
   input  logic               wb_we_i,
   input  logic               wb_cyc_i,
   input  logic               wb_stb_i,
   output u1e_pkg::wb_data_t  wb_dat_o,
   output logic               wb_ack_o,
   input  logic               pps_i,
   input  logic               cgen_st_status_i,
   input  logic               cgen_st_ld_i,
   input  logic               cgen_st_refmon_i,
   output logic [3:0]         led_o,
   output logic               cgen_sync_b_o,
   output logic               cgen_ref_sel_o
  );

   logic core_rst;

   logic misc_stb, misc_ack, rb_stb, rb_ack, sbus_stb, sbus_ack;
   u1e_pkg::wb_data_t misc_dat, rb_dat;

   logic                set_stb;
   u1e_pkg::set_addr_t  set_addr;
   u1e_pkg::set_data_t  set_data;
   u1e_pkg::vita_time_t vita_time, vita_time_pps;

   u1e_reset_ctrl #(.RESET_HOLD(RESET_HOLD)) reset_ctrl
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .set_stb_i(set_stb), .set_addr_i(set_addr),
      .core_rst_o(core_rst));

   //////////////////////////////////////////////////////////////////////
   // bus decode, slaves 0, 7, 8/9
   u1e_bus_decoder bus_decoder
     (.wb_clk(wb_clk), .rst_i(core_rst),
      .wb_adr_i(wb_adr_i), .wb_sel_i(wb_sel_i), .wb_we_i(wb_we_i),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .misc_stb_o(misc_stb), .misc_ack_i(misc_ack), .misc_dat_i(misc_dat),
      .rb_stb_o(rb_stb), .rb_ack_i(rb_ack), .rb_dat_i(rb_dat),
      .set_stb_o(sbus_stb), .set_ack_i(sbus_ack), .set_dat_i(16'h0000));  // write only

   u1e_misc_regs misc_regs
     (.wb_clk(wb_clk), .rst_i(core_rst), .adr_i(wb_adr_i), .dat_i(wb_dat_i),
      .we_i(wb_we_i), .stb_i(misc_stb), .dat_o(misc_dat), .ack_o(misc_ack),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i), .led_o(led_o),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o));

   u1e_settings_bridge settings_bridge
     (.wb_clk(wb_clk), .rst_i(core_rst), .adr_i(wb_adr_i), .dat_i(wb_dat_i),
      .we_i(wb_we_i), .stb_i(sbus_stb), .ack_o(sbus_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   u1e_readback_regs readback_regs
     (.wb_clk(wb_clk), .rst_i(core_rst), .adr_i(wb_adr_i), .stb_i(rb_stb),
      .cyc_i(wb_cyc_i), .dat_o(rb_dat), .ack_o(rb_ack),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps));

   // vita time
   u1e_time_keeper time_keeper
     (.wb_clk(wb_clk), .rst_i(core_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i), .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps));

endmodule

// File: verif/u1e_core_asserts.sv
module u1e_core_asserts
  (
   input logic       wb_clk,
   input logic       wb_rst,
   input logic       wb_cyc_i,
   input logic       wb_stb_i,
   input logic       wb_ack_o,
   input logic       set_stb,
   input logic       core_rst,
   input logic [3:0] led_o,
   input logic       cgen_sync_b_o,
   input logic       cgen_ref_sel_o
  );

   int unsigned fail_count = 0;   // summed into the testbench totals

   ack_in_request : assert property (@(posedge wb_clk) disable iff (wb_rst)
                                     wb_ack_o |-> (wb_cyc_i && wb_stb_i))
   else
   begin
      fail_count++;
      $error("wb_ack_o high without cyc and stb");
   end

   // settings strobe is a single-cycle pulse
   set_stb_pulse : assert property (@(posedge wb_clk) disable iff (wb_rst)
                                    set_stb |=> !set_stb)
   else
   begin
      fail_count++;
      $error("set_stb high for more than one cycle");
   end

   reset_outputs : assert property (@(posedge wb_clk)
                                    core_rst |=> ((led_o == 4'b1111) && cgen_sync_b_o &&
                                                  cgen_ref_sel_o))
   else
   begin
      fail_count++;
      $error("LED or cgen outputs not at reset value during core reset");
   end

endmodule

bind u1e_core u1e_core_asserts core_asserts
  (.wb_clk(wb_clk), .wb_rst(wb_rst), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
   .wb_ack_o(wb_ack_o), .set_stb(set_stb), .core_rst(core_rst), .led_o(led_o),
   .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o));

// File: verif/u1e_core_tb.sv
module u1e_core_tb;

   logic                wb_clk;
   logic                wb_rst;
   u1e_pkg::wb_addr_t   wb_adr_i;
   u1e_pkg::wb_data_t   wb_dat_i;
   u1e_pkg::wb_sel_t    wb_sel_i;
   logic                wb_we_i;
   logic                wb_cyc_i;
   logic                wb_stb_i;
   u1e_pkg::wb_data_t   wb_dat_o;
   logic                wb_ack_o;
   logic                pps_i;
   logic                cgen_st_status_i;
   logic                cgen_st_ld_i;
   logic                cgen_st_refmon_i;
   logic [3:0]          led_o;
   logic                cgen_sync_b_o;
   logic                cgen_ref_sel_o;

   int unsigned cycle_cnt = 0;
   int unsigned checks = 0;
   int unsigned mismatches = 0;
   int unsigned other_errors = 0;
   int          seed = 32'ha4fd;
   bit          ops_ready = 1'b0;

   // one entry per operation line of the input file
   byte         op_q[$];
   logic [31:0] arg_q[$];    // address, or idle cycles for T and P
   logic [63:0] dat_q[$];
   logic [63:0] exp_q[$];

   u1e_core #(.RESET_HOLD(8)) UUT
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
      .wb_sel_i(wb_sel_i), .wb_we_i(wb_we_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .pps_i(pps_i),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i), .led_o(led_o),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o));

   initial
   begin
      wb_clk = 1'b0;
      forever #2 wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk)
      cycle_cnt <= cycle_cnt + 1;

   //////////////////////////////////////////////////////////////////////
   // address helpers, settings number sits in bits 6:1
   function automatic u1e_pkg::wb_addr_t settings_addr(input u1e_pkg::set_addr_t sr,
                                                       input logic odd);
      return {u1e_pkg::SLV_SETTINGS, sr[5:0], odd};
   endfunction

   function automatic u1e_pkg::wb_addr_t readback_addr(input logic [3:0] word, input logic odd);
      return {u1e_pkg::SLV_READBACK, 2'b00, word, odd};
   endfunction

   task automatic check_data(input string name, input u1e_pkg::wb_data_t exp_v,
                             input u1e_pkg::wb_data_t act_v);
      checks++;
      if (act_v !== exp_v)
      begin
         mismatches++;
         $display("MISMATCH %s expected %h actual %h", name, exp_v, act_v);
      end
   endtask

   task automatic check_time(input string name, input u1e_pkg::vita_time_t min_v,
                             input u1e_pkg::vita_time_t max_v, input u1e_pkg::vita_time_t act_v);
      checks++;
      if ((act_v < min_v) || (act_v > max_v) || $isunknown(act_v))
      begin
         mismatches++;
         $display("MISMATCH %s expected %h..%h actual %h", name, min_v, max_v, act_v);
      end
   endtask

   task automatic check_pins(input string name, input logic [3:0] exp_v, input logic [3:0] act_v);
      checks++;
      if (act_v !== exp_v)
      begin
         mismatches++;
         $display("MISMATCH %s expected %b actual %b", name, exp_v, act_v);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // one Wishbone classic access, outputs sampled at the falling edge
   task automatic bus_access(input logic we, input u1e_pkg::wb_addr_t adr,
                             input u1e_pkg::wb_data_t wdat, output u1e_pkg::wb_data_t rdat,
                             output int unsigned start_cyc, output int unsigned ack_cyc);
      @(posedge wb_clk);
      #1;
      wb_adr_i  = adr;
      wb_dat_i  = wdat;
      wb_sel_i  = 2'b11;
      wb_we_i   = we;
      wb_cyc_i  = 1'b1;
      wb_stb_i  = 1'b1;
      start_cyc = cycle_cnt;
      @(negedge wb_clk);
      while (!wb_ack_o)
         @(negedge wb_clk);   // waits out readback latency and core reset
      rdat    = wb_dat_o;
      ack_cyc = cycle_cnt;
      @(posedge wb_clk);
      #1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic write_word(input u1e_pkg::wb_addr_t adr, input u1e_pkg::wb_data_t wdat,
                             output int unsigned ack_cyc);
      u1e_pkg::wb_data_t rdat;
      int unsigned       start_cyc;
      bus_access(1'b1, adr, wdat, rdat, start_cyc, ack_cyc);
   endtask

   task automatic read_word(input u1e_pkg::wb_addr_t adr, output u1e_pkg::wb_data_t rdat,
                            output int unsigned start_cyc);
      int unsigned ack_cyc;
      bus_access(1'b0, adr, 16'h0000, rdat, start_cyc, ack_cyc);
   endtask

   // high word first, the low word load starts the counter
   task automatic load_time(input u1e_pkg::vita_time_t t, output int unsigned ack_cyc);
      write_word(settings_addr(u1e_pkg::SR_TIME64, 1'b0), t[47:32], ack_cyc);
      write_word(settings_addr(u1e_pkg::SR_TIME64, 1'b1), t[63:48], ack_cyc);
      write_word(settings_addr(u1e_pkg::SR_TIME64 + 8'd1, 1'b0), t[15:0], ack_cyc);
      write_word(settings_addr(u1e_pkg::SR_TIME64 + 8'd1, 1'b1), t[31:16], ack_cyc);
   endtask

   // low word first, start_cyc is when its low half was requested
   task automatic read_time(input logic [3:0] hi_word, output u1e_pkg::vita_time_t t,
                            output int unsigned start_cyc);
      u1e_pkg::wb_data_t p0, p1, p2, p3;
      int unsigned       unused_cyc;
      read_word(readback_addr(hi_word + 4'd1, 1'b0), p0, start_cyc);
      read_word(readback_addr(hi_word + 4'd1, 1'b1), p1, unused_cyc);
      read_word(readback_addr(hi_word, 1'b0), p2, unused_cyc);
      read_word(readback_addr(hi_word, 1'b1), p3, unused_cyc);
      t = {p3, p2, p1, p0};
   endtask

   task automatic read_file();
      int          fd;
      int          c;
      int          n;
      logic [31:0] a;
      logic [63:0] d;
      logic [63:0] e;

      fd = $fopen("verif/u1e_core_input.txt", "r");
      if (fd == 0)
      begin
         other_errors++;
         $display("could not open the input file verif/u1e_core_input.txt");
         return;
      end
      c = $fgetc(fd);
      while (c != -1)
      begin
         if (c == "#")
         begin
            while ((c != -1) && (c != "\n"))
               c = $fgetc(fd);   // comment runs to end of line
         end
         else if ((c == "W") || (c == "R") || (c == "T") || (c == "P"))
         begin
            n = $fscanf(fd, "%h %h %h", a, d, e);
            if (n == 3)
            begin
               op_q.push_back(c[7:0]);
               arg_q.push_back(a);
               dat_q.push_back(d);
               exp_q.push_back(e);
            end
            else
            begin
               other_errors++;
               $display("input file has a short line after operation %0d", op_q.size());
            end
         end
         else if ((c != " ") && (c != "\n") && (c != "\r") && (c != "\t"))
         begin
            other_errors++;
            $display("input file has an unknown operation code after operation %0d",
                     op_q.size());
         end
         c = $fgetc(fd);
      end
      $fclose(fd);
   endtask

   //////////////////////////////////////////////////////////////////////
   // one line of the input file
   task automatic run_op(input int idx);
      u1e_pkg::wb_addr_t   adr;
      u1e_pkg::wb_data_t   rdat;
      u1e_pkg::wb_data_t   exp_d;
      u1e_pkg::vita_time_t t_act, t_min, t_max;
      int unsigned         t_ack, s_cyc;
      int                  r;
      string               name;
      logic                is_misc;

      adr     = arg_q[idx][10:0];
      exp_d   = exp_q[idx][15:0];
      is_misc = (adr[10:7] == u1e_pkg::SLV_MISC);
      case (op_q[idx])
         "W":
            write_word(adr, dat_q[idx][15:0], t_ack);
         "R":
         begin
            name = $sformatf("op %0d read 0x%03h", idx + 1, adr);
            if (is_misc && (adr[6:0] == u1e_pkg::REG_CGEN_ST))
            begin
               @(posedge wb_clk);
               #1;
               r = $random(seed);
               cgen_st_status_i = r[2];
               cgen_st_ld_i     = r[1];
               cgen_st_refmon_i = r[0];
               exp_d = {13'd0, r[2], r[1], r[0]};   // status, ld, refmon
            end
            read_word(adr, rdat, s_cyc);
            check_data(name, exp_d, rdat);
            if (is_misc && (adr[6:0] == u1e_pkg::REG_LEDS))
               check_pins({name, " led_o"}, ~exp_d[3:0], led_o);   // active low
            if (is_misc && (adr[6:0] == u1e_pkg::REG_CGEN_CTRL))
               check_pins({name, " cgen pins"}, {2'b00, exp_d[1:0]},
                          {2'b00, cgen_sync_b_o, cgen_ref_sel_o});
         end
         "T":
         begin
            name = $sformatf("op %0d time count", idx + 1);
            load_time(dat_q[idx], t_ack);
            repeat (arg_q[idx]) @(posedge wb_clk);
            read_time(4'd0, t_act, s_cyc);
            // load lands one cycle after the strobe, then a step every other cycle
            t_min = {exp_q[idx][63:32], exp_q[idx][31:0] + (s_cyc - t_ack - 2) / 2};
            t_max = t_min + 64;
            check_time(name, t_min, t_max, t_act);
         end
         "P":
         begin
            name = $sformatf("op %0d pps capture", idx + 1);
            load_time(dat_q[idx], t_ack);
            repeat (arg_q[idx]) @(posedge wb_clk);
            #1;
            pps_i = 1'b1;
            repeat (4) @(posedge wb_clk);
            #1;
            pps_i = 1'b0;
            repeat (4) @(posedge wb_clk);   // sync flops plus edge register
            read_time(4'd2, t_act, s_cyc);
            t_min = exp_q[idx];
            t_max = {exp_q[idx][63:32], exp_q[idx][31:0] + (s_cyc - t_ack) / 2 + 32'd64};
            check_time(name, t_min, t_max, t_act);
         end
         default:
         begin
            other_errors++;
            $display("operation %0d has no handler", idx + 1);
         end
      endcase
   endtask

   initial
   begin
      int          i;
      int unsigned asserts_failed;

      wb_rst           = 1'b1;
      wb_adr_i         = '0;
      wb_dat_i         = '0;
      wb_sel_i         = '0;
      wb_we_i          = 1'b0;
      wb_cyc_i         = 1'b0;
      wb_stb_i         = 1'b0;
      pps_i            = 1'b0;
      cgen_st_status_i = 1'b0;
      cgen_st_ld_i     = 1'b0;
      cgen_st_refmon_i = 1'b0;
      read_file();
      ops_ready = 1'b1;
      repeat (16) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;
      for (i = 0; i < op_q.size(); i++)
         run_op(i);
      repeat (4) @(posedge wb_clk);
      asserts_failed = UUT.core_asserts.fail_count;
      $display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
               checks, mismatches, other_errors, asserts_failed);
      if ((mismatches == 0) && (other_errors == 0) && (asserts_failed == 0))
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

   // watchdog, sized from the number of operations
   initial
   begin
      int unsigned limit;

      wait (ops_ready);
      limit = op_q.size() * 64 + 200;
      repeat (limit) @(posedge wb_clk);
      $display("timeout: operations did not finish within %0d cycles", limit);
      $display("sim failed");
      $finish;
   end

endmodule

// File: verif/u1e_core_input.txt
# op addr data expected, all hex. W write, R read and compare,
# T load time then read it, P load time then pulse pps; for T and P addr is idle cycles
W 000 000a 0000
R 000 0000 000a
W 004 0001 0000
R 004 0000 0001
W 008 5a3c 0000
R 008 0000 5a3c
R 010 0000 0004
R 00a 0000 beef
R 006 0000 0000
R 006 0000 0000
# test32 through the settings bridge
W 468 cafe 0000
W 469 1234 0000
R 388 0000 cafe
R 389 0000 1234
T 0020 0000001200001000 0000001200001000
P 0010 00000abc00200000 00000abc00200000
# unmapped slot 3
R 180 0000 0000
W 188 ffff 0000
R 008 0000 5a3c
W 180 0003 0000
R 000 0000 000a
# global reset
W 000 0003 0000
W 004 0000 0000
W 464 0001 0000
W 465 0000 0000
R 000 0000 0000
R 004 0000 0003
R 388 0000 0000
R 389 0000 0000
R 008 0000 0000
R 380 0000 0000

// File: tb.f
src/u1e_pkg.sv
src/u1e_reset_ctrl.sv
src/u1e_bus_decoder.sv
src/u1e_misc_regs.sv
src/u1e_settings_bridge.sv
src/u1e_time_keeper.sv
src/u1e_readback_regs.sv
src/u1e_core.sv
verif/u1e_core_asserts.sv
verif/u1e_core_tb.sv

// File: Bender.yml
package:
  name: u1e_core

sources:
  - src/u1e_pkg.sv
  - src/u1e_reset_ctrl.sv
  - src/u1e_bus_decoder.sv
  - src/u1e_misc_regs.sv
  - src/u1e_settings_bridge.sv
  - src/u1e_time_keeper.sv
  - src/u1e_readback_regs.sv
  - src/u1e_core.sv
  - target: test
    files:
      - verif/u1e_core_asserts.sv
      - verif/u1e_core_tb.sv
